// ==== src.f ====
+incdir+verilog
verilog/rfPkg.sv
verilog/phaseCounter.sv
verilog/instrSequencer.sv
verilog/operandSelect.sv
verilog/registerFile.sv
verilog/regFileUnit.sv
verif/rfRefModel.sv
verif/regFileUnit_tb.sv

// ==== Makefile ====
# Verilator build and run for the register-file slice

VERILATOR ?= verilator
TOP ?= regFileUnit_tb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS ?= --binary --timing --timescale $(TIMESCALE)
LINTFLAGS ?= --lint-only --timing --timescale $(TIMESCALE)

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module regFileUnit

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/regFileUnit_tb.sv ====
`include "rf_settings.svh"

module regFileUnit_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int ClkPeriod = 40;
	localparam int NumRand = 400;
	localparam int NumDirected = 28;          // Reset sweep plus named register pairs
	localparam int MaxGap = 6;                 // Idle cycles between instructions
	localparam int WatchdogNs = (NumRand + NumDirected) * (`RF_PHASES + MaxGap + 2)
		* ClkPeriod + 30 * ClkPeriod;

	logic clk;
	logic rstN;
	logic instrValid;
	rfPkg::instrWord_u instr;
	rfPkg::rfSources_s sources;
	logic busy;
	logic done;
	logic [`RF_DATA_W-1:0] portAData;
	logic [`RF_DATA_W-1:0] portBData;
	int errors;
	int checks;
	int donePulses;
	logic doneLast;

	regFileUnit dut (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.sources(sources),
		.busy(busy),
		.done(done),
		.portAData(portAData),
		.portBData(portBData)
	);

	rfRefModel model ();

	initial begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	// Done pulse counter, also catches a pulse longer than one cycle
	always @(negedge clk) begin
		if (rstN && done && doneLast) begin
			errors++;
			$display("done stayed high for more than one cycle at %0t", $time);
		end
		if (rstN && done) donePulses++;
		doneLast = done;
	end

	task automatic checkValue(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got 0x%04h expected 0x%04h", name, got, exp);
		end
	endtask

	// Issue one word at a falling edge with busy low, run it to done
	task automatic runInstr(input logic [15:0] word);
		logic [`RF_DATA_W-1:0] expA;
		logic [`RF_DATA_W-1:0] expB;
		int cycles;
		instr = word;
		sources.aluResult = 16'($urandom);     // Held for the whole cycle
		sources.pcValue = 16'($urandom);
		sources.aluAPostInc = 16'($urandom);
		sources.memDin = 16'($urandom);
		instrValid = 1'b1;
		@(negedge clk);
		cycles = 0;                            // Accepting edge just passed
		checks++;
		if (!busy) begin
			errors++;
			$display("busy did not rise after an accepted instruction at %0t", $time);
		end
		while (!done && cycles < 12) begin
			instrValid = ($urandom_range(0, 2) == 0);   // Stray strobe, must be ignored
			instr = 16'($urandom);
			@(negedge clk);
			cycles++;
		end
		instrValid = 1'b0;
		checks++;
		if (!done) begin
			errors++;
			$display("no done pulse within %0d cycles of word 0x%04h", cycles, word);
		end else begin
			if (cycles != `RF_PHASES) begin
				errors++;
				$display("done came %0d cycles after acceptance instead of %0d",
					cycles, `RF_PHASES);
			end
			checkValue("busy", 16'(busy), 16'h0);   // Busy drops with done
			model.retire(word, sources, expA, expB);
			checkValue("portAData", portAData, expA);
			checkValue("portBData", portBData, expB);
		end
	endtask

	initial begin
		int gap;
		logic [1:0] din;
		void'($urandom(32'h4aee));            // Single seed for the whole run
		errors = 0;
		checks = 0;
		donePulses = 0;
		doneLast = 1'b0;
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		sources = '0;
		repeat (10) @(negedge clk);
		rstN = 1'b1;
		@(negedge clk);
		checkValue("busy", 16'(busy), 16'h0);
		checkValue("done", 16'(done), 16'h0);
		checkValue("portAData", portAData, 16'h0);
		checkValue("portBData", portBData, 16'h0);
		for (int i = 0; i < `RF_REGS; i++) begin
			runInstr({2'b00, 2'b00, 3'd0, 1'b0, 4'(i), 4'(i)});   // Read-only sweep
		end
		for (int sel = 1; sel <= 6; sel++) begin
			din = 2'($urandom);
			runInstr({2'b01, din, 3'(sel), 1'b0, 4'($urandom), 4'($urandom)});
			runInstr({2'b00, 2'b00, 3'd0, 1'b0, 4'($urandom), 4'(7 + sel)});  // argB readback
		end
		for (int n = 0; n < NumRand; n++) begin
			gap = $urandom_range(0, MaxGap);
			repeat (gap) @(negedge clk);
			runInstr(16'($urandom));
		end
		repeat (2) @(negedge clk);             // Let the monitor see the last pulse
		checks++;
		if (donePulses != model.accepted) begin
			errors++;
			$display("saw %0d done pulses for %0d accepted instructions",
				donePulses, model.accepted);
		end
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	initial begin
		#(WatchdogNs);
		$display("Watchdog expired before all instructions retired");
		$display("Summary: %0d checks, %0d errors", checks, errors + 1);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== verif/rfRefModel.sv ====
`include "rf_settings.svh"

module rfRefModel;
	timeunit 1ns;
	timeprecision 1ps;

	logic [`RF_DATA_W-1:0] regs [`RF_REGS];   // Expected architectural state
	int accepted;                              // Instructions retired so far

	task automatic clearAll();
		for (int i = 0; i < `RF_REGS; i++) begin
			regs[i] = '0;                      // Matches the reset state
		end
		accepted = 0;
	endtask

	// Port A target, bit slices follow the two word layouts
	function automatic logic [`RF_ADDR_W-1:0] portAIndex(input logic [15:0] w);
		logic [2:0] sel;
		sel = w[11:9];
		if (w[15:14] == 2'b11) begin
			return w[13:10];                   // Immediate form, argA
		end
		if (sel >= 3'd1 && sel <= 3'd6) begin
			return `RF_REG_RL + 4'(sel) - 4'd1;    // RL through RRS
		end
		return w[7:4];                         // argA, code 7 included
	endfunction

	function automatic logic [`RF_ADDR_W-1:0] portBIndex(input logic [15:0] w);
		if (w[15:14] == 2'b11) begin
			return w[13:10];
		end
		if (w[8]) begin
			return w[7:4];                     // Port B follows argA
		end
		return w[3:0];
	endfunction

	// Called once per done pulse, returns pre-write port values
	task automatic retire(input logic [15:0] w, input rfPkg::rfSources_s src,
		output logic [`RF_DATA_W-1:0] expA, output logic [`RF_DATA_W-1:0] expB);
		logic [`RF_ADDR_W-1:0] a;
		a = portAIndex(w);
		expA = regs[a];
		expB = regs[portBIndex(w)];
		accepted++;
		if (w[15:14] == 2'b11) begin
			regs[a] = {{(`RF_DATA_W - `RF_IMM_W){w[9]}}, w[9:0]};   // Sign extend
		end else if (w[15:14] == 2'b01) begin
			case (w[13:12])
				2'd0: regs[a] = src.aluResult;
				2'd1: regs[a] = src.pcValue;
				2'd2: regs[a] = src.aluAPostInc;
				default: regs[a] = src.memDin;
			endcase
		end
	endtask

	initial begin
		clearAll();
	end

endmodule

// ==== verilog/regFileUnit.sv ====
`include "rf_settings.svh"

module regFileUnit (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   instrValid,
	input  rfPkg::instrWord_u      instr,
	input  rfPkg::rfSources_s      sources,     // Levels from ALU, PC and memory
	output logic                   busy,
	output logic                   done,
	output logic [`RF_DATA_W-1:0]  portAData,
	output logic [`RF_DATA_W-1:0]  portBData
);

	rfPkg::rfCtrl_s ctrl;
	logic run;
	logic [1:0] phase;
	logic lastPhase;
	logic readStrobe;
	logic writeStrobe;                          // Already qualified by write enable
	logic [`RF_ADDR_W-1:0] readAddrA;
	logic [`RF_ADDR_W-1:0] readAddrB;
	logic [`RF_ADDR_W-1:0] writeAddr;
	logic [`RF_DATA_W-1:0] writeData;

	instrSequencer uSeq (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.phase(phase),
		.lastPhase(lastPhase),
		.ctrl(ctrl),
		.run(run),
		.readStrobe(readStrobe),
		.writeStrobe(writeStrobe),
		.busy(busy),
		.done(done)
	);

	phaseCounter uPhase (
		.clk(clk),
		.rstN(rstN),
		.run(run),
		.phase(phase),
		.lastPhase(lastPhase)
	);

	operandSelect uSel (
		.ctrl(ctrl),
		.sources(sources),
		.readAddrA(readAddrA),
		.readAddrB(readAddrB),
		.writeAddr(writeAddr),
		.writeData(writeData)
	);

	registerFile uRegs (
		.clk(clk),
		.rstN(rstN),
		.readEn(readStrobe),
		.readAddrA(readAddrA),
		.readAddrB(readAddrB),
		.writeEn(writeStrobe),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.dataA(portAData),
		.dataB(portBData)
	);

endmodule

// ==== verilog/registerFile.sv ====
`include "rf_settings.svh"

module registerFile (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   readEn,      // Registers both read ports
	input  logic [`RF_ADDR_W-1:0]  readAddrA,
	input  logic [`RF_ADDR_W-1:0]  readAddrB,
	input  logic                   writeEn,
	input  logic [`RF_ADDR_W-1:0]  writeAddr,
	input  logic [`RF_DATA_W-1:0]  writeData,
	output logic [`RF_DATA_W-1:0]  dataA,       // Holds until next read
	output logic [`RF_DATA_W-1:0]  dataB
);

	logic [`RF_DATA_W-1:0] regs [`RF_REGS];

	// Read and write never share an edge within one instruction
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < `RF_REGS; i++) begin
				regs[i] <= '0;                  // Architectural state starts clear
			end
			dataA <= '0;
			dataB <= '0;
		end else begin
			if (readEn) begin
				dataA <= regs[readAddrA];
				dataB <= regs[readAddrB];       // May alias port A
			end
			if (writeEn) begin
				regs[writeAddr] <= writeData;
			end
		end
	end

endmodule

// ==== verilog/operandSelect.sv ====
`include "rf_settings.svh"

module operandSelect (
	input  rfPkg::rfCtrl_s         ctrl,
	input  rfPkg::rfSources_s      sources,
	output logic [`RF_ADDR_W-1:0]  readAddrA,
	output logic [`RF_ADDR_W-1:0]  readAddrB,
	output logic [`RF_ADDR_W-1:0]  writeAddr,
	output logic [`RF_DATA_W-1:0]  writeData
);

	logic [`RF_DATA_W-1:0] srcData;

	// Indices come resolved from decode
	assign readAddrA = ctrl.addrA;
	assign readAddrB = ctrl.addrB;
	assign writeAddr = ctrl.addrA;            // Writes only ever use port A

	// Port A source mux, sampled by the array on the write edge
	always_comb begin
		unique case (ctrl.dinSel)
			rfPkg::DIN_ALU_R: begin
				srcData = sources.aluResult;
			end
			rfPkg::DIN_PC: begin
				srcData = sources.pcValue;        // Return address into RL
			end
			rfPkg::DIN_ALUA_PP: begin
				srcData = sources.aluAPostInc;    // Pointer bump, e.g. RSP
			end
			rfPkg::DIN_MEM: begin
				srcData = sources.memDin;         // Loads
			end
			default: begin
				srcData = sources.aluResult;
			end
		endcase
	end

	// Immediate form bypasses the source mux
	always_comb begin
		if (ctrl.immSel) begin
			writeData = ctrl.immValue;
		end else begin
			writeData = srcData;
		end
	end

endmodule

// ==== verilog/instrSequencer.sv ====
`include "rf_settings.svh"

module instrSequencer (
	input  logic               clk,
	input  logic               rstN,
	input  logic               instrValid,   // Single cycle strobe
	input  rfPkg::instrWord_u  instr,
	input  logic [1:0]         phase,
	input  logic               lastPhase,
	output rfPkg::rfCtrl_s     ctrl,         // Latched at acceptance
	output logic               run,
	output logic               readStrobe,
	output logic               writeStrobe,
	output logic               busy,
	output logic               done
);

	typedef enum logic [1:0] {
		stIdle,
		stActive,
		stRetire
	} seqState_e;

	localparam logic [1:0] ReadIdx  = 2'd0;
	localparam logic [1:0] WriteIdx = 2'(`RF_PHASES - 2);   // Write lands entering last phase

	seqState_e state;
	rfPkg::rfCtrl_s decoded;
	logic accept;

	// Decode both views of the word into one control record
	always_comb begin
		decoded = '0;
		if (instr.immF.opClass == rfPkg::OP_IMM) begin
			decoded.addrA = instr.immF.argA;
			decoded.addrB = instr.immF.argA;      // Both ports look at the target
			decoded.writeEn = 1'b1;
			decoded.immSel = 1'b1;
			decoded.immValue = {{(`RF_DATA_W - `RF_IMM_W){instr.immF.imm[`RF_IMM_W-1]}},
				instr.immF.imm};
		end else begin
			unique case (instr.regF.addrASel)
				rfPkg::ASEL_RL:  decoded.addrA = `RF_REG_RL;
				rfPkg::ASEL_RB:  decoded.addrA = `RF_REG_RB;
				rfPkg::ASEL_RA:  decoded.addrA = `RF_REG_RA;
				rfPkg::ASEL_RSP: decoded.addrA = `RF_REG_RSP;
				rfPkg::ASEL_RFP: decoded.addrA = `RF_REG_RFP;
				rfPkg::ASEL_RRS: decoded.addrA = `RF_REG_RRS;
				default:         decoded.addrA = instr.regF.argA;   // argA and code 7
			endcase
			decoded.addrB = (instr.regF.addrBSel == rfPkg::BSEL_ARGA) ?
				instr.regF.argA : instr.regF.argB;
			decoded.writeEn = (instr.regF.opClass == rfPkg::OP_WRITE);   // Reserved reads only
			decoded.dinSel = instr.regF.dinSel;
		end
	end

	assign busy = (state == stActive);
	assign done = (state == stRetire);        // One cycle, retire never lingers
	assign run = busy;
	assign accept = instrValid && !busy;      // Strobes during busy are dropped

	assign readStrobe = busy && (phase == ReadIdx);
	assign writeStrobe = busy && ctrl.writeEn && (phase == WriteIdx);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= stIdle;
			ctrl <= '0;
		end else begin
			if (accept) ctrl <= decoded;
			unique case (state)
				stActive: if (lastPhase) state <= stRetire;
				default:  state <= accept ? stActive : stIdle;   // Idle and retire
			endcase
		end
	end

endmodule

// ==== verilog/phaseCounter.sv ====
`include "rf_settings.svh"

module phaseCounter (
	input  logic       clk,
	input  logic       rstN,
	input  logic       run,        // High for the whole instruction cycle
	output logic [1:0] phase,      // Current phase of the cycle
	output logic       lastPhase   // Final phase, instruction retires next edge
);

	localparam logic [1:0] LastIdx = 2'(`RF_PHASES - 1);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			phase <= '0;
		end else if (!run) begin
			phase <= '0;                // Parked at phase 0 while idle
		end else if (phase == LastIdx) begin
			phase <= '0;                // Wraps if run is held past the cycle
		end else begin
			phase <= phase + 2'd1;
		end
	end

	// Only meaningful while a cycle is running
	assign lastPhase = run && (phase == LastIdx);

endmodule

// ==== verilog/rfPkg.sv ====
`include "rf_settings.svh"

package rfPkg;

	typedef enum logic [1:0] {
		OP_READ  = 2'b00,     // Read both ports only
		OP_WRITE = 2'b01,     // Read, then write port A from a source
		OP_RSVD  = 2'b10,     // Reserved, behaves as read only
		OP_IMM   = 2'b11      // Immediate form
	} opClass_e;

	typedef enum logic [2:0] {
		ASEL_ARGA = 3'd0,     // Port A index from argA
		ASEL_RL   = 3'd1,
		ASEL_RB   = 3'd2,
		ASEL_RA   = 3'd3,
		ASEL_RSP  = 3'd4,
		ASEL_RFP  = 3'd5,
		ASEL_RRS  = 3'd6,
		ASEL_RSVD = 3'd7      // Falls back to argA
	} addrASel_e;

	typedef enum logic {
		BSEL_ARGB = 1'b0,     // Port B index from argB
		BSEL_ARGA = 1'b1      // Port B follows argA
	} addrBSel_e;

	typedef enum logic [1:0] {
		DIN_ALU_R   = 2'd0,   // ALU result
		DIN_PC      = 2'd1,   // Program counter
		DIN_ALUA_PP = 2'd2,   // Post incremented ALU operand A
		DIN_MEM     = 2'd3    // Memory read data
	} dinSel_e;

	typedef struct packed {
		opClass_e opClass;                 // Bits 15:14 in both views
		dinSel_e dinSel;
		addrASel_e addrASel;
		addrBSel_e addrBSel;
		logic [`RF_ADDR_W-1:0] argA;
		logic [`RF_ADDR_W-1:0] argB;
	} regForm_s;

	typedef struct packed {
		opClass_e opClass;
		logic [`RF_ADDR_W-1:0] argA;
		logic [`RF_IMM_W-1:0] imm;         // Signed, extended on decode
	} immForm_s;

	typedef union packed {
		regForm_s regF;
		immForm_s immF;
	} instrWord_u;

	typedef struct packed {
		logic [`RF_ADDR_W-1:0] addrA;      // Resolved port A index
		logic [`RF_ADDR_W-1:0] addrB;      // Resolved port B index
		logic writeEn;
		dinSel_e dinSel;
		logic immSel;                      // Write the immediate instead of a source
		logic [`RF_DATA_W-1:0] immValue;
	} rfCtrl_s;

	typedef struct packed {
		logic [`RF_DATA_W-1:0] aluResult;
		logic [`RF_DATA_W-1:0] pcValue;
		logic [`RF_DATA_W-1:0] aluAPostInc;
		logic [`RF_DATA_W-1:0] memDin;
	} rfSources_s;

endpackage

// ==== verilog/rf_settings.svh ====
`ifndef RF_SETTINGS_SVH
`define RF_SETTINGS_SVH

// Datapath sizing
`define RF_DATA_W 16            // One machine word
`define RF_REGS 16              // Entries in the array
`define RF_ADDR_W 4             // Register index width
`define RF_IMM_W 10             // Immediate field of the immediate form

// Instruction cycle
`define RF_PHASES 4             // Clocks per instruction cycle

// Architectural register numbers
`define RF_REG_RL 4'd8          // Link register
`define RF_REG_RB 4'd9          // Base register
`define RF_REG_RA 4'd10         // Accumulator
`define RF_REG_RSP 4'd11        // Data stack pointer
`define RF_REG_RFP 4'd12        // Frame pointer
`define RF_REG_RRS 4'd13        // Return stack pointer

// Low registers 0 to 7 and 14, 15 are general purpose
// and are only reachable through argA or argB

`endif
